// File: rv_isa_pkg.sv
/* rv32i subset isa definitions
   base word types, opcode and funct field encodings, ecall word */
`default_nettype none

package rv_isa_pkg;

  typedef logic [31:0] word_t;    // data or byte address
  typedef logic [31:0] instr_t;   // raw instruction word
  typedef logic [4:0]  reg_idx_t; // x0..x31

  // major opcodes, instr[6:0]
  localparam logic [6:0] OP_R      = 7'b0110011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  // funct3 for alu ops, instr[14:12]
  localparam logic [2:0] F3_ADD = 3'b000; // add, sub, addi
  localparam logic [2:0] F3_SLL = 3'b001;
  localparam logic [2:0] F3_SLT = 3'b010;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_SRL = 3'b101;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;

  // funct3 for branches
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;
  localparam logic [2:0] F3_BLT = 3'b100;
  localparam logic [2:0] F3_BGE = 3'b101;

  localparam logic [6:0] F7_ALT = 7'b0100000; // sub when opcode is OP_R

  localparam instr_t INSTR_ECALL = 32'h0000_0073; // halts the core

endpackage

`default_nettype wire

// File: cpu_ctrl_pkg.sv
/* datapath control types
   alu operation select, writeback source, branch condition code */
`default_nettype none

package cpu_ctrl_pkg;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SLT
  } alu_op_t;

  typedef enum logic [1:0] {
    WB_ALU, // alu result
    WB_MEM, // load data
    WB_PC4  // link address for jal/jalr
  } wb_src_t;

  typedef logic [2:0] branch_t; // funct3 of the branch, read by the alu

endpackage

`default_nettype wire

// File: pc_unit.sv
/* program counter unit
   holds pc, forms pc+4 and pc+imm, picks the next pc */
`timescale 1ns/1ps
`default_nettype none

module pc_unit (
  input  wire logic              clk,
  input  wire logic              reset,
  input  wire logic              hold,        // freeze on halt
  input  wire logic              take_target, // jal or taken branch
  input  wire logic              jalr,
  input  wire rv_isa_pkg::word_t imm,
  input  wire rv_isa_pkg::word_t jalr_target, // rs1 + imm from alu
  output rv_isa_pkg::word_t      pc,
  output rv_isa_pkg::word_t      pc_plus4
);

  rv_isa_pkg::word_t pc_target; // branch / jal destination
  rv_isa_pkg::word_t next_pc;

  assign pc_plus4  = pc + 32'd4;
  assign pc_target = pc + imm;

  // jalr wins, then pc-relative target, else fall through
  always_comb begin
    if (jalr) begin
      next_pc = {jalr_target[31:1], 1'b0}; // lsb cleared per isa
    end else if (take_target) begin
      next_pc = pc_target;
    end else begin
      next_pc = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (!hold) begin
      pc <= next_pc;
    end
  end

endmodule

`default_nettype wire

// File: instruction_memory.sv
/* instruction memory
   word array, async fetch, boot-load write port used during reset */
`timescale 1ns/1ps
`default_nettype none

module instruction_memory #(
  parameter int IMEM_WORDS = 256
) (
  input  wire logic               clk,
  input  wire rv_isa_pkg::word_t  addr,      // byte address from pc
  output rv_isa_pkg::instr_t      instr,
  input  wire logic               prog_we,   // boot-load strobe
  input  wire rv_isa_pkg::word_t  prog_addr, // byte address
  input  wire rv_isa_pkg::instr_t prog_data
);

  localparam int AW = $clog2(IMEM_WORDS); // word index width

  rv_isa_pkg::instr_t mem [0:IMEM_WORDS-1];

  assign instr = mem[addr[AW+1:2]]; // wraps modulo depth

  always_ff @(posedge clk) begin
    if (prog_we) begin
      mem[prog_addr[AW+1:2]] <= prog_data;
    end
  end

endmodule

`default_nettype wire

// File: register_file.sv
/* integer register file
   32 x 32, two async reads, one sync write, x0 reads zero */
`timescale 1ns/1ps
`default_nettype none

module register_file (
  input  wire logic                 clk,
  input  wire logic                 reset,
  input  wire rv_isa_pkg::reg_idx_t rs1,
  input  wire rv_isa_pkg::reg_idx_t rs2,
  input  wire rv_isa_pkg::reg_idx_t rd,
  input  wire rv_isa_pkg::word_t    rd_data,
  input  wire logic                 write_enable,
  output rv_isa_pkg::word_t         rs1_data,
  output rv_isa_pkg::word_t         rs2_data,
  output rv_isa_pkg::word_t         print_reg [0:31] // debug view of all regs
);

  rv_isa_pkg::word_t regs [0:31];

  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1]; // x0 hard zero
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (write_enable && rd != 5'd0) begin // x0 writes dropped
      regs[rd] <= rd_data;
    end
  end

  assign print_reg[0] = '0;
  for (genvar g = 1; g < 32; g++) begin : g_print
    assign print_reg[g] = regs[g];
  end

endmodule

`default_nettype wire

// File: immediate_generator.sv
/* immediate generator
   picks I, S, B or J layout from the opcode and sign-extends to 32 bits */
`timescale 1ns/1ps
`default_nettype none

module immediate_generator (
  input  wire rv_isa_pkg::instr_t instr,
  output rv_isa_pkg::word_t       imm
);

  logic [6:0] opcode;
  logic       sign; // instr[31] in every format

  assign opcode = instr[6:0];
  assign sign   = instr[31];

  always_comb begin
    case (opcode)
      rv_isa_pkg::OP_IMM,
      rv_isa_pkg::OP_LOAD,
      rv_isa_pkg::OP_JALR: begin // I: [31:20]
        imm = {{20{sign}}, instr[31:20]};
      end
      rv_isa_pkg::OP_STORE: begin // S: split at rd position
        imm = {{20{sign}}, instr[31:25], instr[11:7]};
      end
      rv_isa_pkg::OP_BRANCH: begin // B: even offset, 13 bits
        imm = {{19{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};
      end
      rv_isa_pkg::OP_JAL: begin // J: even offset, 21 bits
        imm = {{11{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      default: begin
        imm = '0; // r-type, system, unknown
      end
    endcase
  end

endmodule

`default_nettype wire

// File: control_unit.sv
/* main control and alu-op decode
   opcode to datapath controls, funct3/funct7 to alu op, ecall to halt */
`timescale 1ns/1ps
`default_nettype none

module control_unit (
  input  wire rv_isa_pkg::instr_t instr,
  output cpu_ctrl_pkg::alu_op_t   alu_op,
  output logic                    alu_src,   // b operand is imm
  output logic                    branch,
  output logic                    jal,
  output logic                    jalr,
  output logic                    mem_write,
  output logic                    reg_write,
  output logic                    halted,    // level while on ecall
  output cpu_ctrl_pkg::wb_src_t   wb_src
);

  logic [6:0]            opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  cpu_ctrl_pkg::alu_op_t func_op; // op implied by funct fields

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign halted = (instr == rv_isa_pkg::INSTR_ECALL);

  // funct decode, shared by r-type and op-imm
  always_comb begin
    case (funct3)
      rv_isa_pkg::F3_ADD: begin
        // sub only for r-type, addi has imm bits here
        if (opcode == rv_isa_pkg::OP_R && funct7 == rv_isa_pkg::F7_ALT) begin
          func_op = cpu_ctrl_pkg::ALU_SUB;
        end else begin
          func_op = cpu_ctrl_pkg::ALU_ADD;
        end
      end
      rv_isa_pkg::F3_SLL: func_op = cpu_ctrl_pkg::ALU_SLL;
      rv_isa_pkg::F3_SLT: func_op = cpu_ctrl_pkg::ALU_SLT;
      rv_isa_pkg::F3_XOR: func_op = cpu_ctrl_pkg::ALU_XOR;
      rv_isa_pkg::F3_SRL: func_op = cpu_ctrl_pkg::ALU_SRL;
      rv_isa_pkg::F3_OR:  func_op = cpu_ctrl_pkg::ALU_OR;
      rv_isa_pkg::F3_AND: func_op = cpu_ctrl_pkg::ALU_AND;
      default:            func_op = cpu_ctrl_pkg::ALU_ADD; // sltu not kept
    endcase
  end

  // main decoder, defaults mean no side effects
  always_comb begin
    alu_op    = cpu_ctrl_pkg::ALU_ADD;
    alu_src   = 1'b0;
    branch    = 1'b0;
    jal       = 1'b0;
    jalr      = 1'b0;
    mem_write = 1'b0;
    reg_write = 1'b0;
    wb_src    = cpu_ctrl_pkg::WB_ALU;
    case (opcode)
      rv_isa_pkg::OP_R: begin
        reg_write = 1'b1;
        alu_op    = func_op;
      end
      rv_isa_pkg::OP_IMM: begin
        reg_write = 1'b1;
        alu_src   = 1'b1;
        alu_op    = func_op;
      end
      rv_isa_pkg::OP_LOAD: begin // address = rs1 + imm
        reg_write = 1'b1;
        alu_src   = 1'b1;
        wb_src    = cpu_ctrl_pkg::WB_MEM;
      end
      rv_isa_pkg::OP_STORE: begin
        alu_src   = 1'b1;
        mem_write = 1'b1;
      end
      rv_isa_pkg::OP_BRANCH: branch = 1'b1; // compare done on rs1/rs2
      rv_isa_pkg::OP_JAL: begin
        jal       = 1'b1;
        reg_write = 1'b1;
        wb_src    = cpu_ctrl_pkg::WB_PC4;
      end
      rv_isa_pkg::OP_JALR: begin // alu forms rs1 + imm
        jalr      = 1'b1;
        reg_write = 1'b1;
        alu_src   = 1'b1;
        wb_src    = cpu_ctrl_pkg::WB_PC4;
      end
      rv_isa_pkg::OP_SYSTEM: ; // ecall, handled by halted
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: alu.sv
/* alu
   eight integer ops plus the branch condition on a and b */
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  wire cpu_ctrl_pkg::alu_op_t alu_op,
  input  wire cpu_ctrl_pkg::branch_t funct,  // branch funct3
  input  wire rv_isa_pkg::word_t     a,
  input  wire rv_isa_pkg::word_t     b,
  output rv_isa_pkg::word_t          result,
  output logic                       bcond   // branch taken
);

  logic [4:0] shamt;
  logic       lt_s;  // signed a < b
  logic       eq;

  assign shamt = b[4:0];
  assign lt_s  = ($signed(a) < $signed(b));
  assign eq    = (a == b);

  always_comb begin
    case (alu_op)
      cpu_ctrl_pkg::ALU_ADD: result = a + b;
      cpu_ctrl_pkg::ALU_SUB: result = a - b;
      cpu_ctrl_pkg::ALU_AND: result = a & b;
      cpu_ctrl_pkg::ALU_OR:  result = a | b;
      cpu_ctrl_pkg::ALU_XOR: result = a ^ b;
      cpu_ctrl_pkg::ALU_SLL: result = a << shamt;
      cpu_ctrl_pkg::ALU_SRL: result = a >> shamt; // logical only
      cpu_ctrl_pkg::ALU_SLT: result = {31'b0, lt_s};
      default:               result = '0;
    endcase
  end

  // only meaningful when control asserts branch
  always_comb begin
    case (funct)
      rv_isa_pkg::F3_BEQ: bcond = eq;
      rv_isa_pkg::F3_BNE: bcond = !eq;
      rv_isa_pkg::F3_BLT: bcond = lt_s;
      rv_isa_pkg::F3_BGE: bcond = !lt_s;
      default:            bcond = 1'b0; // unsigned compares not kept
    endcase
  end

endmodule

`default_nettype wire

// File: data_memory.sv
/* data memory
   word array, async read, sync write, zeroed while reset is high */
`timescale 1ns/1ps
`default_nettype none

module data_memory #(
  parameter int DMEM_WORDS = 64
) (
  input  wire logic              clk,
  input  wire logic              reset,
  input  wire rv_isa_pkg::word_t addr,         // byte address from alu
  input  wire rv_isa_pkg::word_t wdata,        // rs2 for sw
  input  wire logic              write_enable,
  output rv_isa_pkg::word_t      rdata
);

  localparam int AW = $clog2(DMEM_WORDS);

  rv_isa_pkg::word_t mem [0:DMEM_WORDS-1];
  logic [AW-1:0]     idx; // word index, wraps modulo depth

  assign idx   = addr[AW+1:2];
  assign rdata = mem[idx];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < DMEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (write_enable) begin
      mem[idx] <= wdata;
    end
  end

endmodule

`default_nettype wire

// File: cpu.sv
/* single-cycle rv32i subset core
   wires the datapath, operand and writeback muxes, halt freeze */
`timescale 1ns/1ps
`default_nettype none

module cpu #(
  parameter int IMEM_WORDS = 256,
  parameter int DMEM_WORDS = 64
) (
  input  wire logic               reset,
  input  wire logic               clk,
  input  wire logic               prog_we,   // boot-load, used under reset
  input  wire rv_isa_pkg::word_t  prog_addr,
  input  wire rv_isa_pkg::instr_t prog_data,
  output logic                    is_halted,
  output rv_isa_pkg::word_t       print_reg [0:31]
);

  rv_isa_pkg::word_t     pc, pc_plus4, imm, rs1_data, rs2_data;
  rv_isa_pkg::word_t     alu_b, result, rdata, rd_data;
  rv_isa_pkg::instr_t    instr;
  cpu_ctrl_pkg::alu_op_t alu_op;
  cpu_ctrl_pkg::wb_src_t wb_src;
  cpu_ctrl_pkg::branch_t br_funct;
  logic alu_src, branch, jal, jalr, mem_write, reg_write, halted, bcond;
  logic take_target, reg_we, mem_we;

  assign br_funct    = instr[14:12];
  assign alu_b       = alu_src ? imm : rs2_data;
  assign take_target = jal | (branch & bcond); // pc-relative redirect
  assign reg_we      = reg_write & ~halted & ~reset; // frozen on ecall
  assign mem_we      = mem_write & ~halted & ~reset;
  assign is_halted   = halted;

  always_comb begin
    case (wb_src)
      cpu_ctrl_pkg::WB_MEM: rd_data = rdata;
      cpu_ctrl_pkg::WB_PC4: rd_data = pc_plus4; // link value
      default:              rd_data = result;
    endcase
  end

  pc_unit pc_u (.clk(clk), .reset(reset), .hold(halted), .take_target(take_target),
    .jalr(jalr), .imm(imm), .jalr_target(result), .pc(pc), .pc_plus4(pc_plus4));

  instruction_memory #(.IMEM_WORDS(IMEM_WORDS)) imem (.clk(clk), .addr(pc),
    .instr(instr), .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data));

  register_file rf (.clk(clk), .reset(reset), .rs1(instr[19:15]), .rs2(instr[24:20]),
    .rd(instr[11:7]), .rd_data(rd_data), .write_enable(reg_we),
    .rs1_data(rs1_data), .rs2_data(rs2_data), .print_reg(print_reg));

  control_unit ctrl (.instr(instr), .alu_op(alu_op), .alu_src(alu_src), .branch(branch),
    .jal(jal), .jalr(jalr), .mem_write(mem_write), .reg_write(reg_write),
    .halted(halted), .wb_src(wb_src));

  immediate_generator imm_gen (.instr(instr), .imm(imm));

  alu alu_u (.alu_op(alu_op), .funct(br_funct), .a(rs1_data), .b(alu_b),
    .result(result), .bcond(bcond));

  data_memory #(.DMEM_WORDS(DMEM_WORDS)) dmem (.clk(clk), .reset(reset), .addr(result),
    .wdata(rs2_data), .write_enable(mem_we), .rdata(rdata));

endmodule

`default_nettype wire

// File: tb_cpu.sv
/* testbench for the single-cycle core
   boots each program under reset, runs it to ecall and checks all
   registers and the halt level against an isa model */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;

  localparam int IMEM_WORDS = 256;
  localparam int DMEM_WORDS = 64;

  logic               clk;
  logic               reset;
  logic               prog_we;
  rv_isa_pkg::word_t  prog_addr;
  rv_isa_pkg::instr_t prog_data;
  logic               is_halted;
  rv_isa_pkg::word_t  print_reg [0:31];

  rv_isa_pkg::instr_t prog [$];               // program under test
  rv_isa_pkg::word_t  model_regs [0:31];      // expected registers
  rv_isa_pkg::word_t  model_mem [0:DMEM_WORDS-1];
  int run_cycles  = 0; // cycles out of reset, whole run
  int cycle_limit = 0; // grows per test
  int errs;
  int pass_count  = 0;
  int fail_count  = 0;

  cpu #(.IMEM_WORDS(IMEM_WORDS), .DMEM_WORDS(DMEM_WORDS)) cpu_inst (
    .clk(clk), .reset(reset), .prog_we(prog_we), .prog_addr(prog_addr),
    .prog_data(prog_data), .is_halted(is_halted), .print_reg(print_reg));

  always #2 clk = ~clk; // 4 ns period

  // watchdog, programs are forward-only so length + 20 is enough
  always @(posedge clk) begin
    if (!reset) begin
      run_cycles++;
      if (run_cycles > cycle_limit) begin
        $display("timeout: core ran %0d cycles without reaching ecall", run_cycles);
        $display("=== FAIL ===");
        $finish;
      end
    end
  end

  function automatic rv_isa_pkg::instr_t enc_r(logic [6:0] f7, logic [2:0] f3, int rd,
                                               int rs1, int rs2);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), rv_isa_pkg::OP_R};
  endfunction

  function automatic rv_isa_pkg::instr_t enc_i(logic [6:0] op, logic [2:0] f3, int rd,
                                               int rs1, rv_isa_pkg::word_t imm);
    return {imm[11:0], 5'(rs1), f3, 5'(rd), op};
  endfunction

  function automatic rv_isa_pkg::instr_t enc_addi(int rd, int rs1, rv_isa_pkg::word_t imm);
    return enc_i(rv_isa_pkg::OP_IMM, rv_isa_pkg::F3_ADD, rd, rs1, imm);
  endfunction

  function automatic rv_isa_pkg::instr_t enc_lw(int rd, int rs1, rv_isa_pkg::word_t imm);
    return enc_i(rv_isa_pkg::OP_LOAD, 3'b010, rd, rs1, imm); // funct3 010 is word
  endfunction

  function automatic rv_isa_pkg::instr_t enc_s(int rs1, int rs2, rv_isa_pkg::word_t imm);
    return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], rv_isa_pkg::OP_STORE};
  endfunction

  function automatic rv_isa_pkg::instr_t enc_b(logic [2:0] f3, int rs1, int rs2,
                                               rv_isa_pkg::word_t off);
    return {off[12], off[10:5], 5'(rs2), 5'(rs1), f3, off[4:1], off[11],
            rv_isa_pkg::OP_BRANCH};
  endfunction

  function automatic rv_isa_pkg::instr_t enc_j(int rd, rv_isa_pkg::word_t off);
    return {off[20], off[10:1], off[11], off[19:12], 5'(rd), rv_isa_pkg::OP_JAL};
  endfunction

  // reference arithmetic straight from the isa text
  function automatic rv_isa_pkg::word_t alu_ref(logic [2:0] f3, logic alt,
                                                rv_isa_pkg::word_t a, rv_isa_pkg::word_t b);
    case (f3)
      rv_isa_pkg::F3_ADD: return alt ? a - b : a + b;
      rv_isa_pkg::F3_SLL: return a << b[4:0];
      rv_isa_pkg::F3_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      rv_isa_pkg::F3_XOR: return a ^ b;
      rv_isa_pkg::F3_SRL: return a >> b[4:0];
      rv_isa_pkg::F3_OR:  return a | b;
      default:            return a & b;
    endcase
  endfunction

  function automatic logic taken_ref(logic [2:0] f3, rv_isa_pkg::word_t a,
                                     rv_isa_pkg::word_t b);
    case (f3)
      rv_isa_pkg::F3_BEQ: return a == b;
      rv_isa_pkg::F3_BNE: return a != b;
      rv_isa_pkg::F3_BLT: return $signed(a) < $signed(b);
      default:            return $signed(a) >= $signed(b);
    endcase
  endfunction

  function automatic int mem_index(rv_isa_pkg::word_t addr);
    return int'(addr >> 2) % DMEM_WORDS; // word index modulo depth
  endfunction

  // isa model, runs prog from address 0 up to the first ecall
  task automatic run_model(output int n_steps);
    rv_isa_pkg::word_t  pc, a, b, imm_i, val, next_pc;
    rv_isa_pkg::instr_t ins;
    logic wr;
    int steps;
    int idx;
    pc = '0;
    steps = 0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
      model_mem[i] = '0;
    end
    ins = prog[0];
    while (ins != rv_isa_pkg::INSTR_ECALL && steps < IMEM_WORDS) begin
      a = model_regs[ins[19:15]];
      b = model_regs[ins[24:20]];
      imm_i = {{20{ins[31]}}, ins[31:20]};
      next_pc = pc + 4;
      wr = 1'b1;
      val = pc + 4; // link value unless replaced
      case (ins[6:0])
        rv_isa_pkg::OP_R:    val = alu_ref(ins[14:12], ins[30], a, b);
        rv_isa_pkg::OP_IMM:  val = alu_ref(ins[14:12], 1'b0, a, imm_i);
        rv_isa_pkg::OP_LOAD: val = model_mem[mem_index(a + imm_i)];
        rv_isa_pkg::OP_STORE: begin
          wr = 1'b0;
          model_mem[mem_index(a + {{20{ins[31]}}, ins[31:25], ins[11:7]})] = b;
        end
        rv_isa_pkg::OP_BRANCH: begin
          wr = 1'b0;
          if (taken_ref(ins[14:12], a, b)) begin
            next_pc = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
          end
        end
        rv_isa_pkg::OP_JAL:  next_pc = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        rv_isa_pkg::OP_JALR: next_pc = (a + imm_i) & ~32'd1;
        default:             wr = 1'b0;
      endcase
      if (wr && ins[11:7] != 5'd0) begin
        model_regs[ins[11:7]] = val;
      end
      pc = next_pc;
      steps++;
      idx = int'(pc >> 2);
      ins = (idx < prog.size()) ? prog[idx] : rv_isa_pkg::INSTR_ECALL;
    end
    n_steps = steps;
  endtask

  task automatic check_word(string name, int idx, rv_isa_pkg::word_t exp,
                            rv_isa_pkg::word_t act);
    if (act !== exp) begin
      $display("[ERROR] %s x%0d expected %h actual %h", name, idx, exp, act);
      errs++;
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("[ERROR] %s is_halted expected %b actual %b", name, exp, act);
      errs++;
    end
  endtask

  task automatic compare_regs(string name);
    for (int i = 0; i < 32; i++) begin
      check_word(name, i, model_regs[i], print_reg[i]);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #0.5; // drive and sample just after the edge
  endtask

  // boot under reset, run to ecall, optionally stay halted a while
  task automatic run_program(string name, int freeze);
    int halt_steps; // instructions executed before the ecall
    errs = 0;
    cycle_limit += prog.size() + 20;
    run_model(halt_steps);
    reset = 1'b1;
    foreach (prog[i]) begin
      prog_we   = 1'b1;
      prog_addr = i * 4;
      prog_data = prog[i];
      next_cycle();
    end
    prog_we = 1'b0;
    repeat (2) next_cycle();
    reset = 1'b0;
    repeat (halt_steps) begin // one instruction per clock
      check_flag(name, 1'b0, is_halted);
      next_cycle();
    end
    compare_regs(name);
    check_flag(name, 1'b1, is_halted);
    repeat (freeze) begin
      next_cycle();
      check_flag(name, 1'b1, is_halted);
    end
    if (freeze > 0) compare_regs(name); // nothing may change while frozen
    if (errs == 0) begin
      pass_count++;
      $display("%s: ok", name);
    end else begin
      fail_count++;
      $display("%s: %0d mismatches", name, errs);
    end
  endtask

  // random forward-only program on x0..x15, ends in ecall
  task automatic make_random_program();
    int n, t, rd, rs1, rs2, imm;
    logic [2:0] f3;
    prog.delete();
    n = 2 + int'($urandom % 39); // words incl. ecall
    for (int i = 0; i < n - 1; i++) begin
      rd  = int'($urandom % 16);
      rs1 = int'($urandom % 16);
      rs2 = int'($urandom % 16);
      f3  = 3'($urandom % 8);
      if (f3 == 3'b011) f3 = rv_isa_pkg::F3_ADD; // sltu not in subset
      if (f3 == rv_isa_pkg::F3_SLL || f3 == rv_isa_pkg::F3_SRL) imm = int'($urandom % 32);
      else imm = int'($urandom % 64) - 32;
      t = i + 1 + int'($urandom % (n - 1 - i)); // next instr .. ecall
      case ($urandom % 8)
        0, 1: prog.push_back(enc_r(($urandom % 2 == 1 && f3 == rv_isa_pkg::F3_ADD) ?
                                   rv_isa_pkg::F7_ALT : 7'd0, f3, rd, rs1, rs2));
        2, 3: prog.push_back(enc_i(rv_isa_pkg::OP_IMM, f3, rd, rs1, imm));
        4:    prog.push_back(enc_lw(rd, 0, int'($urandom % 128) * 4)); // may wrap
        5:    prog.push_back(enc_s(0, rs2, int'($urandom % 128) * 4));
        6:    prog.push_back(enc_b({1'($urandom), 1'b0, 1'($urandom)}, rs1, rs2, (t - i) * 4));
        default: begin
          if ($urandom % 2 == 1) prog.push_back(enc_j(rd, (t - i) * 4));
          else prog.push_back(enc_i(rv_isa_pkg::OP_JALR, 3'b000, rd, 0, t * 4));
        end
      endcase
    end
    prog.push_back(rv_isa_pkg::INSTR_ECALL);
  endtask

  initial begin
    logic [2:0] f3s [0:6];
    clk       = 1'b0;
    reset     = 1'b1;
    prog_we   = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    void'($urandom(32'h3bfdf3b8));
    f3s = '{rv_isa_pkg::F3_ADD, rv_isa_pkg::F3_SLL, rv_isa_pkg::F3_SLT, rv_isa_pkg::F3_XOR,
            rv_isa_pkg::F3_SRL, rv_isa_pkg::F3_OR, rv_isa_pkg::F3_AND};

    prog.delete();
    repeat (4) prog.push_back(rv_isa_pkg::INSTR_ECALL);
    run_program("reset_state", 0);

    prog.delete();
    prog.push_back(enc_addi(1, 0, -7));
    prog.push_back(enc_addi(2, 0, 12));
    prog.push_back(enc_r(rv_isa_pkg::F7_ALT, rv_isa_pkg::F3_ADD, 3, 1, 2)); // negative diff
    prog.push_back(enc_r(rv_isa_pkg::F7_ALT, rv_isa_pkg::F3_ADD, 4, 2, 1));
    for (int k = 0; k < 7; k++) begin
      prog.push_back(enc_r(7'd0, f3s[k], 5 + k, 1, 2));
      prog.push_back(enc_i(rv_isa_pkg::OP_IMM, f3s[k], 12 + k, 1,
                           (k == 1 || k == 4) ? 3 : k * 300 - 900)); // shifts use shamt
    end
    prog.push_back(enc_r(7'd0, rv_isa_pkg::F3_SLT, 19, 2, 1));
    prog.push_back(enc_i(rv_isa_pkg::OP_IMM, rv_isa_pkg::F3_SLT, 20, 1, -3));
    prog.push_back(rv_isa_pkg::INSTR_ECALL);
    run_program("arith", 0);

    prog.delete();
    prog.push_back(enc_addi(1, 0, 100));
    prog.push_back(enc_addi(2, 0, -1234));
    prog.push_back(enc_addi(3, 0, 2047));
    prog.push_back(enc_addi(5, 0, 40));
    prog.push_back(enc_s(0, 1, 0));
    prog.push_back(enc_s(0, 2, 8));
    prog.push_back(enc_s(0, 3, 252)); // last word
    prog.push_back(enc_s(0, 1, 264)); // past the end, lands on word 2
    prog.push_back(enc_s(5, 2, 4));
    prog.push_back(enc_lw(10, 0, 0));
    prog.push_back(enc_lw(11, 0, 8));
    prog.push_back(enc_lw(12, 0, 252));
    prog.push_back(enc_lw(13, 0, 520));
    prog.push_back(enc_lw(14, 5, 4));
    prog.push_back(enc_lw(15, 5, -4));
    prog.push_back(rv_isa_pkg::INSTR_ECALL);
    run_program("memory", 0);

    // same words again, fresh reset must have cleared them
    prog.delete();
    prog.push_back(enc_lw(1, 0, 0));
    prog.push_back(enc_lw(2, 0, 8));
    prog.push_back(enc_lw(3, 0, 252));
    prog.push_back(enc_lw(4, 0, 44));
    prog.push_back(rv_isa_pkg::INSTR_ECALL);
    run_program("memory_reset", 0);

    prog.delete();
    prog.push_back(enc_addi(1, 0, 5));
    prog.push_back(enc_addi(2, 0, -3));
    for (int k = 0; k < 12; k++) begin // each branch may jump over one addi
      prog.push_back(enc_b({k[1], 1'b0, k[0]}, (k >= 4 && k < 8) ? 2 : 1, (k < 4) ? 2 : 1, 8));
      prog.push_back(enc_addi(10 + k, 0, k + 1));
    end
    prog.push_back(enc_j(22, 8));
    prog.push_back(enc_addi(23, 0, 9)); // skipped
    prog.push_back(enc_i(rv_isa_pkg::OP_JALR, 3'b000, 24, 0, 124));
    prog.push_back(enc_addi(25, 0, 10));
    prog.push_back(enc_addi(26, 0, 11));
    prog.push_back(enc_i(rv_isa_pkg::OP_JALR, 3'b000, 27, 1, 128)); // odd sum, lsb dropped
    prog.push_back(enc_addi(28, 0, 12));
    prog.push_back(rv_isa_pkg::INSTR_ECALL);
    run_program("control", 0);

    prog.delete();
    prog.push_back(enc_addi(1, 0, 11));
    prog.push_back(enc_addi(2, 0, 22));
    prog.push_back(rv_isa_pkg::INSTR_ECALL);
    prog.push_back(enc_addi(1, 0, 99)); // must never run
    prog.push_back(enc_addi(3, 0, 33));
    prog.push_back(rv_isa_pkg::INSTR_ECALL);
    run_program("halt_freeze", 10);

    for (int p = 0; p < 30; p++) begin
      make_random_program();
      run_program($sformatf("random_%0d", p), 0);
    end

    $display("tests passed %0d failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
rv_isa_pkg.sv
cpu_ctrl_pkg.sv
pc_unit.sv
instruction_memory.sv
register_file.sv
immediate_generator.sv
control_unit.sv
alu.sv
data_memory.sv
cpu.sv
tb_cpu.sv

// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build tb_cpu with Verilator, run it, log to $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --timescale 1ns/1ps -f verilog.f --top-module tb_cpu -Mdir obj_dir
	./obj_dir/Vtb_cpu | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
